// ==== verilog/dcache_cfg.svh ====
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// cache geometry
`define DCACHE_NUM_WAYS   6
`define DCACHE_NUM_SETS   8
`define DCACHE_INDEX_W    3    // log2 of the set count
`define DCACHE_WORD_OFS_W 3    // 8 words of 32 bits per line
`define DCACHE_TAG_W      24   // 32 - index - word - byte bits
`define DCACHE_WAY_W      3    // enough for way numbers 0..5

// line and burst shape
`define DCACHE_LINE_W     256  // 32 bytes
`define DCACHE_BEATS      8    // one 32-bit beat per word

// each memory burst moves exactly one line
`endif

// ==== verilog/dcache_pkg.sv ====
`include "dcache_cfg.svh"

package dcache_pkg;

  // split view of a cpu byte address
  typedef struct packed {
    logic [`DCACHE_TAG_W-1:0]      tag;      // compared against the way tags
    logic [`DCACHE_INDEX_W-1:0]    index;    // set select
    logic [`DCACHE_WORD_OFS_W-1:0] word;     // word within the line
    logic [1:0]                    byte_ofs; // zero for word accesses
  } dcache_addr_fields_t;

  // same 32 bits, flat or decoded
  typedef union packed {
    logic [31:0]         raw;
    dcache_addr_fields_t f;
  } dcache_addr_t;

  typedef enum logic [2:0] {
    IDLE,       // waiting for a cpu request
    LOOKUP_WR,  // write merge, req ready
    LOOKUP_RD,  // word capture, req ready
    RESPOND,    // read data out to cpu
    WB_REQ,     // dirty victim address out
    WB_DATA,    // 8 write-back beats
    FILL_REQ,   // refill address out
    FILL_DATA   // 8 refill beats into the victim way
  } dcache_state_t;

endpackage

// ==== verilog/dcache_way_if.sv ====
`timescale 1ns/10ps
`include "dcache_cfg.svh"

interface dcache_way_if;

  // from the controller, shared by every way
  dcache_pkg::dcache_addr_t    addr;       // tag and index of the request
  logic                        wr_hit;     // merge strobe, the way checks its own hit
  logic [31:0]                 wdata;
  logic [3:0]                  wstrb;
  logic                        fill;       // one refill beat for this way
  logic [31:0]                 fill_data;

  // from the way, combinational on addr
  logic                        hit;
  logic                        dirty;
  logic [`DCACHE_TAG_W-1:0]    tag;
  logic [`DCACHE_LINE_W-1:0]   line;

  modport ctrl (output addr, wr_hit, wdata, wstrb, fill, fill_data);

  modport way (input addr, wr_hit, wdata, wstrb, fill, fill_data,
               output hit, dirty, tag, line);

  modport sel (input hit, dirty, tag, line);  // selector only looks

endinterface

// ==== verilog/dcache_way.sv ====
`timescale 1ns/10ps
`include "dcache_cfg.svh"

module dcache_way (
  input logic      clk,
  input logic      rst,
  dcache_way_if.way bus
);

  logic [`DCACHE_NUM_SETS-1:0] valid_q;                         // per set
  logic [`DCACHE_NUM_SETS-1:0] dirty_q;
  logic [`DCACHE_TAG_W-1:0]    tag_mem  [`DCACHE_NUM_SETS];
  logic [`DCACHE_LINE_W-1:0]   line_mem [`DCACHE_NUM_SETS];
  logic [`DCACHE_INDEX_W-1:0]  idx;
  logic [2:0]                  fill_cnt;                        // beats taken so far
  logic                        hit;
  logic                        wr_en;                           // merge this cycle
  logic [`DCACHE_LINE_W-1:0]   merged;

  assign idx   = bus.addr.f.index;
  assign hit   = valid_q[idx] && (tag_mem[idx] == bus.addr.f.tag);
  assign wr_en = bus.wr_hit && hit;

  // lookup side, all combinational
  assign bus.hit   = hit;
  assign bus.dirty = dirty_q[idx];
  assign bus.tag   = tag_mem[idx];
  assign bus.line  = line_mem[idx];

  // byte merge into the addressed word
  always_comb begin
    merged = line_mem[idx];
    for (int b = 0; b < 4; b++) begin
      if (bus.wstrb[b])
        merged[32 * bus.addr.f.word + 8 * b +: 8] = bus.wdata[8 * b +: 8];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q  <= '0;
      dirty_q  <= '0;
      fill_cnt <= '0;
    end else if (bus.fill) begin
      fill_cnt     <= fill_cnt + 3'd1;
      valid_q[idx] <= (fill_cnt == 3'd7);  // invalid while partly refilled
      dirty_q[idx] <= 1'b0;                // fresh copy of memory
    end else if (wr_en) begin
      dirty_q[idx] <= 1'b1;
    end
  end

  // line and tag storage
  always_ff @(posedge clk) begin
    if (bus.fill) begin
      // beats enter at the top, word 0 ends up in the low bits
      line_mem[idx] <= {bus.fill_data, line_mem[idx][`DCACHE_LINE_W-1:32]};
      if (fill_cnt == 3'd7)
        tag_mem[idx] <= bus.addr.f.tag;    // line complete
    end else if (wr_en) begin
      line_mem[idx] <= merged;
    end
  end

endmodule

// ==== verilog/dcache_way_select.sv ====
`timescale 1ns/10ps
`include "dcache_cfg.svh"

module dcache_way_select (
  input  logic                        clk,
  input  logic                        rst,
  dcache_way_if.sel                   ways [`DCACHE_NUM_WAYS],
  input  dcache_pkg::dcache_addr_t    addr,
  input  logic                        touch,        // lru update for the hit way
  output logic                        hit_any,
  output logic [31:0]                 hit_word,
  output logic [`DCACHE_WAY_W-1:0]    victim_way,
  output logic                        victim_dirty,
  output logic [`DCACHE_TAG_W-1:0]    victim_tag,
  output logic [`DCACHE_LINE_W-1:0]   victim_line
);

  logic [`DCACHE_NUM_WAYS-1:0] hit_v;
  logic [`DCACHE_NUM_WAYS-1:0] dirty_v;
  logic [`DCACHE_TAG_W-1:0]    tag_v  [`DCACHE_NUM_WAYS];
  logic [`DCACHE_LINE_W-1:0]   line_v [`DCACHE_NUM_WAYS];
  logic [`DCACHE_WAY_W-1:0]    age    [`DCACHE_NUM_SETS][`DCACHE_NUM_WAYS];  // 0 = newest
  logic [`DCACHE_WAY_W-1:0]    hit_way;
  logic [`DCACHE_INDEX_W-1:0]  idx;

  // interface arrays only take constant indices, so flatten them first
  for (genvar g = 0; g < `DCACHE_NUM_WAYS; g++) begin : g_flat
    assign hit_v[g]   = ways[g].hit;
    assign dirty_v[g] = ways[g].dirty;
    assign tag_v[g]   = ways[g].tag;
    assign line_v[g]  = ways[g].line;
  end

  assign idx     = addr.f.index;
  assign hit_any = |hit_v;

  // lowest numbered hit wins
  always_comb begin
    hit_way = '0;
    for (int w = `DCACHE_NUM_WAYS - 1; w >= 0; w--) begin
      if (hit_v[w])
        hit_way = w[`DCACHE_WAY_W-1:0];
    end
  end

  assign hit_word = line_v[hit_way][32 * addr.f.word +: 32];

  // oldest way of the set goes out
  always_comb begin
    victim_way = '0;
    for (int w = 0; w < `DCACHE_NUM_WAYS; w++) begin
      if (age[idx][w] == `DCACHE_WAY_W'(`DCACHE_NUM_WAYS - 1))
        victim_way = w[`DCACHE_WAY_W-1:0];
    end
  end

  assign victim_dirty = dirty_v[victim_way];
  assign victim_tag   = tag_v[victim_way];
  assign victim_line  = line_v[victim_way];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < `DCACHE_NUM_SETS; s++)
        for (int w = 0; w < `DCACHE_NUM_WAYS; w++)
          age[s][w] <= w[`DCACHE_WAY_W-1:0];  // ages form a permutation per set
    end else if (touch && hit_any) begin
      for (int w = 0; w < `DCACHE_NUM_WAYS; w++) begin
        if (w == hit_way)
          age[idx][w] <= '0;
        else if (age[idx][w] < age[idx][hit_way])
          age[idx][w] <= age[idx][w] + 1'b1;  // older ones keep their age
      end
    end
  end

endmodule

// ==== verilog/dcache_ctrl.sv ====
`timescale 1ns/10ps
`include "dcache_cfg.svh"

module dcache_ctrl (
  input  logic                        clk,
  input  logic                        rst,
  // cpu request
  input  logic                        cpu_req_valid,
  input  logic                        cpu_req_wr,
  input  logic [31:0]                 cpu_req_addr,
  input  logic [31:0]                 cpu_req_wdata,
  input  logic [3:0]                  cpu_req_wstrb,
  output logic                        cpu_req_ready,
  // cpu read response
  output logic                        cpu_rsp_valid,
  output logic [31:0]                 cpu_rsp_data,
  input  logic                        cpu_rsp_ready,
  // memory read
  output logic                        mem_rd_req_valid,
  output logic [31:0]                 mem_rd_req_addr,
  input  logic                        mem_rd_req_ready,
  input  logic                        mem_rd_rsp_valid,
  input  logic [31:0]                 mem_rd_rsp_data,
  input  logic                        mem_rd_rsp_last,
  output logic                        mem_rd_rsp_ready,
  // memory write
  output logic                        mem_wr_req_valid,
  output logic [31:0]                 mem_wr_req_addr,
  input  logic                        mem_wr_req_ready,
  output logic                        mem_wr_data_valid,
  output logic [31:0]                 mem_wr_data,
  output logic                        mem_wr_data_last,
  input  logic                        mem_wr_data_ready,
  // ways and selector
  dcache_way_if.ctrl                  ways [`DCACHE_NUM_WAYS],
  input  logic                        hit_any,
  input  logic [31:0]                 hit_word,
  input  logic [`DCACHE_WAY_W-1:0]    victim_way,
  input  logic                        victim_dirty,
  input  logic [`DCACHE_TAG_W-1:0]    victim_tag,
  input  logic [`DCACHE_LINE_W-1:0]   victim_line,
  output logic                        touch
);

  dcache_pkg::dcache_state_t       state;
  dcache_pkg::dcache_state_t       state_nxt;
  dcache_pkg::dcache_addr_t        req;        // decoded request address
  logic [`DCACHE_LINE_W-1:0]       wb_shift;   // victim line, word 0 at the bottom
  logic [`DCACHE_WORD_OFS_W-1:0]   beat_cnt;   // write-back beats sent
  logic [31:0]                     rsp_data_q;
  logic                            wb_beat;
  logic                            fill_beat;
  logic                            wb_done;

  assign req.raw = cpu_req_addr;  // held by the cpu until ready

  assign wb_beat   = (state == dcache_pkg::WB_DATA) && mem_wr_data_ready;
  assign fill_beat = (state == dcache_pkg::FILL_DATA) && mem_rd_rsp_valid;
  assign wb_done   = wb_beat && (beat_cnt == `DCACHE_WORD_OFS_W'(`DCACHE_BEATS - 1));

  always_comb begin
    state_nxt = state;  // stall by default
    case (state)
      dcache_pkg::IDLE: begin
        if (cpu_req_valid) begin
          if (hit_any)
            state_nxt = cpu_req_wr ? dcache_pkg::LOOKUP_WR : dcache_pkg::LOOKUP_RD;
          else
            state_nxt = victim_dirty ? dcache_pkg::WB_REQ : dcache_pkg::FILL_REQ;
        end
      end
      dcache_pkg::LOOKUP_WR: state_nxt = dcache_pkg::IDLE;  // no response on writes
      dcache_pkg::LOOKUP_RD: state_nxt = dcache_pkg::RESPOND;
      dcache_pkg::RESPOND: begin
        if (cpu_rsp_ready)
          state_nxt = dcache_pkg::IDLE;
      end
      dcache_pkg::WB_REQ: begin
        if (mem_wr_req_ready)
          state_nxt = dcache_pkg::WB_DATA;
      end
      dcache_pkg::WB_DATA: begin
        if (wb_done)
          state_nxt = dcache_pkg::FILL_REQ;
      end
      dcache_pkg::FILL_REQ: begin
        if (mem_rd_req_ready)
          state_nxt = dcache_pkg::FILL_DATA;
      end
      dcache_pkg::FILL_DATA: begin
        // line now valid, replay the request as a hit
        if (fill_beat && mem_rd_rsp_last)
          state_nxt = cpu_req_wr ? dcache_pkg::LOOKUP_WR : dcache_pkg::LOOKUP_RD;
      end
      default: state_nxt = dcache_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= dcache_pkg::IDLE;
      beat_cnt <= '0;
    end else begin
      state <= state_nxt;
      if (wb_beat)
        beat_cnt <= beat_cnt + 1'b1;  // wraps to 0 after beat 8
    end
  end

  // write-back shifter and read data holding
  always_ff @(posedge clk) begin
    if ((state == dcache_pkg::WB_REQ) && mem_wr_req_ready)
      wb_shift <= victim_line;
    else if (wb_beat)
      wb_shift <= {32'b0, wb_shift[`DCACHE_LINE_W-1:32]};
    if (state == dcache_pkg::LOOKUP_RD)
      rsp_data_q <= hit_word;  // cpu may change the address after ready
  end

  // cpu side
  assign cpu_req_ready = (state == dcache_pkg::LOOKUP_RD) || (state == dcache_pkg::LOOKUP_WR);
  assign touch         = cpu_req_ready;  // every completed access refreshes its way
  assign cpu_rsp_valid = (state == dcache_pkg::RESPOND);
  assign cpu_rsp_data  = rsp_data_q;

  // memory side, all line aligned
  assign mem_wr_req_valid  = (state == dcache_pkg::WB_REQ);
  assign mem_wr_req_addr   = {victim_tag, req.f.index, 5'b0};
  assign mem_wr_data_valid = (state == dcache_pkg::WB_DATA);
  assign mem_wr_data       = wb_shift[31:0];
  assign mem_wr_data_last  = mem_wr_data_valid &&
                             (beat_cnt == `DCACHE_WORD_OFS_W'(`DCACHE_BEATS - 1));
  assign mem_rd_req_valid  = (state == dcache_pkg::FILL_REQ);
  assign mem_rd_req_addr   = {req.f.tag, req.f.index, 5'b0};
  assign mem_rd_rsp_ready  = (state == dcache_pkg::FILL_DATA);

  // per-way strobes, refill goes only to the victim
  for (genvar g = 0; g < `DCACHE_NUM_WAYS; g++) begin : g_way
    assign ways[g].addr      = req;
    assign ways[g].wr_hit    = (state == dcache_pkg::LOOKUP_WR);
    assign ways[g].wdata     = cpu_req_wdata;
    assign ways[g].wstrb     = cpu_req_wstrb;
    assign ways[g].fill      = fill_beat && (victim_way == g);
    assign ways[g].fill_data = mem_rd_rsp_data;
  end

endmodule

// ==== verilog/dcache_top.sv ====
`timescale 1ns/10ps
`include "dcache_cfg.svh"

module dcache_top (
  input  logic        clk,
  input  logic        rst,
  input  logic        cpu_req_valid,
  input  logic        cpu_req_wr,     // 1 write, 0 read
  input  logic [31:0] cpu_req_addr,
  input  logic [31:0] cpu_req_wdata,
  input  logic [3:0]  cpu_req_wstrb,
  output logic        cpu_req_ready,
  output logic        cpu_rsp_valid,
  output logic [31:0] cpu_rsp_data,
  input  logic        cpu_rsp_ready,
  output logic        mem_rd_req_valid,
  output logic [31:0] mem_rd_req_addr,
  input  logic        mem_rd_req_ready,
  input  logic        mem_rd_rsp_valid,
  input  logic [31:0] mem_rd_rsp_data,
  input  logic        mem_rd_rsp_last,
  output logic        mem_rd_rsp_ready,
  output logic        mem_wr_req_valid,
  output logic [31:0] mem_wr_req_addr,
  input  logic        mem_wr_req_ready,
  output logic        mem_wr_data_valid,
  output logic [31:0] mem_wr_data,
  output logic        mem_wr_data_last,
  input  logic        mem_wr_data_ready
);

  // selector to controller
  logic                        hit_any;
  logic [31:0]                 hit_word;
  logic [`DCACHE_WAY_W-1:0]    victim_way;
  logic                        victim_dirty;
  logic [`DCACHE_TAG_W-1:0]    victim_tag;
  logic [`DCACHE_LINE_W-1:0]   victim_line;
  logic                        touch;

  dcache_way_if way_bus [`DCACHE_NUM_WAYS] ();  // one bundle per way

  dcache_ctrl u_ctrl (.*, .ways(way_bus));

  for (genvar g = 0; g < `DCACHE_NUM_WAYS; g++) begin : g_way
    dcache_way u_way (.clk(clk), .rst(rst), .bus(way_bus[g]));
  end

  dcache_way_select u_sel (
    .clk, .rst,
    .ways(way_bus),
    .addr(cpu_req_addr),  // same request the controller sees
    .touch,
    .hit_any, .hit_word,
    .victim_way, .victim_dirty, .victim_tag, .victim_line
  );

endmodule

// ==== verification/dcache_clkgen.sv ====
`timescale 1ns/10ps

module dcache_clkgen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
  end

  // reset held over the first 4 rising edges
  initial begin
    rst = 1'b1;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

// ==== verification/dcache_mem_model.sv ====
`timescale 1ns/10ps

module dcache_mem_model (
  input  logic        clk,
  input  logic        rst,
  input  logic        mem_rd_req_valid,
  input  logic [31:0] mem_rd_req_addr,
  output logic        mem_rd_req_ready,
  output logic        mem_rd_rsp_valid,
  output logic [31:0] mem_rd_rsp_data,
  output logic        mem_rd_rsp_last,
  input  logic        mem_rd_rsp_ready,
  input  logic        mem_wr_req_valid,
  input  logic [31:0] mem_wr_req_addr,
  output logic        mem_wr_req_ready,
  input  logic        mem_wr_data_valid,
  input  logic [31:0] mem_wr_data,
  input  logic        mem_wr_data_last,
  output logic        mem_wr_data_ready,
  output int          rd_reqs,       // accepted read bursts
  output int          wr_reqs,       // accepted write-back bursts
  output int          wr_beats,      // write-back beats taken in total
  output int          wr_last_beat,  // beat number that carried last, 1 based
  output logic [31:0] rd_addr_seen,
  output logic [31:0] wr_addr_seen
);

  localparam int WORDS = 4096;  // 16 KB window, higher addresses alias

  logic [31:0] mem [WORDS];
  integer      seed = 32'h98d2;

  function automatic logic [11:0] word_index(input logic [31:0] addr);
    return addr[13:2];
  endfunction

  // 0 to 3 idle cycles before a request is taken
  task automatic accept_delay();
    int wait_cycles;
    wait_cycles = $random(seed) & 3;
    repeat (wait_cycles) @(posedge clk);
  endtask

  task automatic serve_read();
    logic [31:0] base;
    accept_delay();
    base = mem_rd_req_addr;  // still held, valid waits for ready
    mem_rd_req_ready <= 1'b1;
    @(posedge clk);
    mem_rd_req_ready <= 1'b0;
    rd_reqs          <= rd_reqs + 1;
    rd_addr_seen     <= base;
    for (int b = 0; b < 8; b++) begin
      mem_rd_rsp_valid <= 1'b1;
      mem_rd_rsp_data  <= mem[word_index(base + 32'(b * 4))];
      mem_rd_rsp_last  <= (b == 7);
      do @(posedge clk); while (!mem_rd_rsp_ready);  // beat moves on ready
    end
    mem_rd_rsp_valid <= 1'b0;
    mem_rd_rsp_last  <= 1'b0;
  endtask

  task automatic absorb_write();
    logic [31:0] base;
    int          beat;
    accept_delay();
    base = mem_wr_req_addr;
    mem_wr_req_ready <= 1'b1;
    @(posedge clk);
    mem_wr_req_ready  <= 1'b0;
    wr_reqs           <= wr_reqs + 1;
    wr_addr_seen      <= base;
    wr_last_beat      <= 0;
    mem_wr_data_ready <= 1'b1;
    beat = 0;
    while (beat < 8) begin
      @(posedge clk);
      if (mem_wr_data_valid) begin
        mem[word_index(base + 32'(beat * 4))] = mem_wr_data;  // ascending words
        if (mem_wr_data_last)
          wr_last_beat <= beat + 1;
        beat++;
      end
    end
    wr_beats          <= wr_beats + beat;
    mem_wr_data_ready <= 1'b0;
  endtask

  initial begin
    for (int i = 0; i < WORDS; i++)
      mem[i] = 32'(i * 4) ^ 32'h5a5a5a5a;  // word address xor fixed pattern
    mem_rd_req_ready  <= 1'b0;
    mem_rd_rsp_valid  <= 1'b0;
    mem_rd_rsp_data   <= '0;
    mem_rd_rsp_last   <= 1'b0;
    mem_wr_req_ready  <= 1'b0;
    mem_wr_data_ready <= 1'b0;
    rd_reqs           <= 0;
    wr_reqs           <= 0;
    wr_beats          <= 0;
    wr_last_beat      <= 0;
    rd_addr_seen      <= '0;
    wr_addr_seen      <= '0;
    forever begin
      @(posedge clk);
      if (!rst && mem_rd_req_valid)
        serve_read();
      else if (!rst && mem_wr_req_valid)
        absorb_write();
    end
  end

endmodule

// ==== verification/dcache_chk.sv ====
`timescale 1ns/10ps

module dcache_chk (
  input logic        clk,
  input logic        rst,
  input logic        cpu_rsp_valid,
  input logic [31:0] cpu_rsp_data,
  input logic        cpu_rsp_ready,
  input logic        mem_rd_req_valid,
  input logic        mem_wr_req_valid,
  input logic        mem_wr_req_ready,
  input logic        mem_wr_data_valid,
  input logic        mem_wr_data_last,
  input logic        mem_wr_data_ready
);

  int         fails = 0;   // assertion failure count
  logic       wr_pending;  // write-back accepted, last beat not yet taken
  logic [2:0] wr_beat;     // data beats taken in the current burst

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_pending <= 1'b0;
      wr_beat    <= '0;
    end else if (mem_wr_req_valid && mem_wr_req_ready) begin
      wr_pending <= 1'b1;  // burst starts
      wr_beat    <= '0;
    end else if (mem_wr_data_valid && mem_wr_data_ready) begin
      wr_beat <= wr_beat + 1'b1;
      if (mem_wr_data_last)
        wr_pending <= 1'b0;
    end
  end

  // response held steady while stalled
  a_rsp_hold: assert property (@(posedge clk) disable iff (rst)
    cpu_rsp_valid && !cpu_rsp_ready |=> cpu_rsp_valid && $stable(cpu_rsp_data))
    else begin
      $error("read response dropped or changed before ready");
      fails++;
    end

  // last only with valid and only on the eighth beat
  a_last_valid: assert property (@(posedge clk) disable iff (rst)
    mem_wr_data_last |-> mem_wr_data_valid && (wr_beat == 3'd7))
    else begin
      $error("write data last without valid or not on beat 8");
      fails++;
    end

  // refill never starts before the write-back finished
  a_rd_after_wb: assert property (@(posedge clk) disable iff (rst)
    wr_pending |-> !mem_rd_req_valid)
    else begin
      $error("read request while write-back pending");
      fails++;
    end

endmodule

bind dcache_top dcache_chk u_chk (.*);

// ==== verification/dcache_tb.sv ====
`timescale 1ns/10ps

module dcache_tb;

  // about 25 accesses, a dirty miss stays under 40 cycles, so wide margin
  localparam int TIMEOUT_CYCLES = 4000;
  localparam int MEM_WORDS      = 4096;  // same window as the memory model

  logic        clk, rst;
  logic        cpu_req_valid, cpu_req_wr, cpu_req_ready;
  logic [31:0] cpu_req_addr, cpu_req_wdata;
  logic [3:0]  cpu_req_wstrb;
  logic        cpu_rsp_valid, cpu_rsp_ready;
  logic [31:0] cpu_rsp_data;
  logic        mem_rd_req_valid, mem_rd_req_ready, mem_rd_rsp_valid;
  logic        mem_rd_rsp_last, mem_rd_rsp_ready;
  logic [31:0] mem_rd_req_addr, mem_rd_rsp_data;
  logic        mem_wr_req_valid, mem_wr_req_ready, mem_wr_data_valid;
  logic        mem_wr_data_last, mem_wr_data_ready;
  logic [31:0] mem_wr_req_addr, mem_wr_data;
  int          rd_reqs, wr_reqs, wr_beats, wr_last_beat;  // memory model counters
  logic [31:0] rd_addr_seen, wr_addr_seen;

  logic [31:0] shadow [MEM_WORDS];  // expected memory image
  int          errors = 0;
  int          checks = 0;
  int          tests  = 0;
  int          cycles = 0;

  dcache_clkgen    u_clkgen (.clk, .rst);
  dcache_top       DUT (.*);
  dcache_mem_model u_mem (.*);

  always @(posedge clk) begin
    cycles++;
    if (cycles == TIMEOUT_CYCLES) begin
      $display("timeout: run still busy after %0d cycles", TIMEOUT_CYCLES);
      $display("TB FAILED");
      $finish;
    end
  end

  function automatic logic [11:0] word_index(input logic [31:0] addr);
    return addr[13:2];
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old,
                                              input logic [31:0] data,
                                              input logic [3:0] strb);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++)
      if (strb[b])
        res[8 * b +: 8] = data[8 * b +: 8];  // byte b follows strobe bit b
    return res;
  endfunction

  task automatic compare(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("FAIL %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic finish_test(input string name, input int errors_before);
    tests++;
    $display("%s: done, %0d mismatches", name, errors - errors_before);
  endtask

  // one cpu transfer, lat counts edges from drive to sampled ready
  task automatic cpu_access(input logic wr, input logic [31:0] addr,
                            input logic [31:0] wdata, input logic [3:0] wstrb,
                            output logic [31:0] rdata, output int lat);
    @(posedge clk);
    cpu_req_valid <= 1'b1;
    cpu_req_wr    <= wr;
    cpu_req_addr  <= addr;
    cpu_req_wdata <= wdata;
    cpu_req_wstrb <= wstrb;
    lat = 0;
    do begin
      @(posedge clk);
      lat++;
    end while (!cpu_req_ready);
    cpu_req_valid <= 1'b0;
    rdata = '0;
    if (!wr) begin
      do @(posedge clk); while (!cpu_rsp_valid);  // one stalled cycle seen here
      cpu_rsp_ready <= 1'b1;
      @(posedge clk);
      rdata = cpu_rsp_data;
      cpu_rsp_ready <= 1'b0;
    end
  endtask

  task automatic cpu_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, output int lat);
    logic [31:0] unused;
    cpu_access(1'b1, addr, data, strb, unused, lat);
    shadow[word_index(addr)] = merge_bytes(shadow[word_index(addr)], data, strb);
  endtask

  task automatic read_and_check(input string name, input logic [31:0] addr,
                                output int lat);
    logic [31:0] rdata;
    cpu_access(1'b0, addr, 32'h0, 4'h0, rdata, lat);
    compare(name, shadow[word_index(addr)], rdata);
  endtask

  task automatic reset_and_first_read();
    int e0, rd0, lat;
    e0 = errors;
    compare("reset cpu_req_ready", 32'd0, cpu_req_ready);
    compare("reset cpu_rsp_valid", 32'd0, cpu_rsp_valid);
    compare("reset mem_rd_req_valid", 32'd0, mem_rd_req_valid);
    compare("reset mem_wr_req_valid", 32'd0, mem_wr_req_valid);
    compare("reset mem_wr_data_valid", 32'd0, mem_wr_data_valid);
    compare("reset mem_rd_rsp_ready", 32'd0, mem_rd_rsp_ready);
    rd0 = rd_reqs;
    read_and_check("first read data", 32'h124, lat);
    compare("first read requests", rd0 + 1, rd_reqs);
    compare("first read address", 32'h120, rd_addr_seen);  // line aligned
    finish_test("reset_and_first_read", e0);
  endtask

  task automatic same_line_hit();
    int e0, rd0, wr0, lat;
    e0  = errors;
    rd0 = rd_reqs;
    wr0 = wr_reqs;
    read_and_check("same line data", 32'h13c, lat);
    compare("same line ready latency", 32'd2, lat);  // valid seen in IDLE, ready next
    compare("same line read requests", rd0, rd_reqs);
    compare("same line write requests", wr0, wr_reqs);
    finish_test("same_line_hit", e0);
  endtask

  task automatic write_hit_merge();
    int e0, rd0, wr0, lat;
    e0  = errors;
    rd0 = rd_reqs;
    wr0 = wr_reqs;
    cpu_write(32'h128, 32'hdeadbeef, 4'b0101, lat);
    compare("write hit ready latency", 32'd2, lat);
    read_and_check("write hit merged data", 32'h128, lat);
    compare("write hit read requests", rd0, rd_reqs);
    compare("write hit write requests", wr0, wr_reqs);
    finish_test("write_hit_merge", e0);
  endtask

  task automatic write_miss_refill();
    int e0, rd0, lat;
    e0  = errors;
    rd0 = rd_reqs;
    cpu_write(32'h2a4, 32'h12345678, 4'b1100, lat);
    compare("write miss read requests", rd0 + 1, rd_reqs);
    compare("write miss refill address", 32'h2a0, rd_addr_seen);
    read_and_check("write miss merged data", 32'h2a4, lat);
    read_and_check("write miss other word", 32'h2b8, lat);
    finish_test("write_miss_refill", e0);
  endtask

  // set 2, six dirty tags then a seventh
  task automatic dirty_eviction();
    int e0, wr0, wb0, lat;
    e0 = errors;
    for (int t = 0; t < 6; t++)
      cpu_write(32'h1044 + 32'(t) * 32'h100, 32'h0ace0000 + 32'(t), 4'hf, lat);
    wr0 = wr_reqs;
    wb0 = wr_beats;
    read_and_check("eviction new tag data", 32'h1644, lat);
    compare("eviction write requests", wr0 + 1, wr_reqs);
    compare("eviction write-back address", 32'h1040, wr_addr_seen);  // touched first
    compare("eviction write-back beats", wb0 + 8, wr_beats);
    compare("eviction last beat", 32'd8, wr_last_beat);
    compare("eviction refill address", 32'h1640, rd_addr_seen);
    read_and_check("evicted line reread", 32'h1044, lat);  // comes back from memory
    compare("evicted line refill address", 32'h1040, rd_addr_seen);
    finish_test("dirty_eviction", e0);
  endtask

  // set 3, refreshing the oldest tag moves the victim to the next one
  task automatic lru_refresh();
    int e0, wr0, lat;
    e0 = errors;
    for (int t = 0; t < 6; t++)
      cpu_write(32'h2068 + 32'(t) * 32'h100, 32'h0bee0000 + 32'(t), 4'hf, lat);
    read_and_check("refresh oldest line", 32'h2068, lat);
    wr0 = wr_reqs;
    read_and_check("refresh new tag data", 32'h2668, lat);
    compare("refresh write requests", wr0 + 1, wr_reqs);
    compare("refresh write-back address", 32'h2160, wr_addr_seen);
    finish_test("lru_refresh", e0);
  endtask

  initial begin
    cpu_req_valid <= 1'b0;
    cpu_req_wr    <= 1'b0;
    cpu_req_addr  <= '0;
    cpu_req_wdata <= '0;
    cpu_req_wstrb <= '0;
    cpu_rsp_ready <= 1'b0;
    for (int i = 0; i < MEM_WORDS; i++)
      shadow[i] = 32'(i * 4) ^ 32'h5a5a5a5a;  // untouched words keep the fill pattern
    while (rst !== 1'b0)
      @(posedge clk);
    @(posedge clk);
    reset_and_first_read();
    same_line_hit();
    write_hit_merge();
    write_miss_refill();
    dirty_eviction();
    lru_refresh();
    repeat (2) @(posedge clk);
    $display("summary: %0d tests, %0d checks, %0d mismatches, %0d assertion failures",
             tests, checks, errors, DUT.u_chk.fails);
    if (errors == 0 && DUT.u_chk.fails == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== dcache.f ====
+incdir+verilog
verilog/dcache_pkg.sv
verilog/dcache_way_if.sv
verilog/dcache_way.sv
verilog/dcache_way_select.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
verification/dcache_clkgen.sv
verification/dcache_mem_model.sv
verification/dcache_chk.sv
verification/dcache_tb.sv

// ==== Bender.yml ====
package:
  name: dcache

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/dcache_pkg.sv
      - verilog/dcache_way_if.sv
      - verilog/dcache_way.sv
      - verilog/dcache_way_select.sv
      - verilog/dcache_ctrl.sv
      - verilog/dcache_top.sv
  - target: simulation
    files:
      - verification/dcache_clkgen.sv
      - verification/dcache_mem_model.sv
      - verification/dcache_chk.sv
      - verification/dcache_tb.sv
